//--- hw/immu.sv
`timescale 1ns/100ps

module immu import immu_pkg::*; #(
    parameter int NUM_4K = 32,
    parameter int NUM_SP = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    // privilege and satp
    input  logic [1:0]         current_priv_status,
    input  logic [3:0]         satp_mode,
    input  logic [ASID_W-1:0]  satp_asid,
    // flushes
    input  logic               flush_flag,
    input  logic               sflush_vma_valid,
    // page walker
    output logic               immu_miss_valid,
    input  logic               immu_miss_ready,
    input  logic               pte_valid,
    output logic               pte_ready,
    input  logic [PTE_W-1:0]   pte,
    input  logic               pte_error,
    // fetch queue
    input  logic               mmu_fifo_valid,
    output logic               mmu_fifo_ready,
    input  logic [VADDR_W-1:0] vaddr,
    // icache
    output logic               paddr_valid,
    input  logic               paddr_ready,
    output logic [VADDR_W-1:0] paddr,
    output logic               paddr_error
);

    logic miss;
    logic advance;
    logic walk_resp;
    logic walk_error;
    logic fill;

    tlb_lookup_if lk_4k ();
    tlb_lookup_if lk_sp ();

    //************************************************************
    // shared lookup inputs
    //************************************************************
    assign lk_4k.vaddr       = vaddr;
    assign lk_4k.asid        = satp_asid;
    assign lk_4k.lookup_take = mmu_fifo_ready;
    assign lk_4k.fill        = fill;
    assign lk_4k.fill_pte    = pte;

    assign lk_sp.vaddr       = vaddr;
    assign lk_sp.asid        = satp_asid;
    assign lk_sp.lookup_take = mmu_fifo_ready;
    assign lk_sp.fill        = fill;
    assign lk_sp.fill_pte    = pte;

    tlb_4k_array #(
        .NUM_4K (NUM_4K)
    ) u_tlb_4k (
        .clk    (clk),
        .rst_n  (rst_n),
        .sflush (sflush_vma_valid),
        .lk     (lk_4k.array)
    );

    tlb_sp_array #(
        .NUM_SP (NUM_SP)
    ) u_tlb_sp (
        .clk    (clk),
        .rst_n  (rst_n),
        .sflush (sflush_vma_valid),
        .lk     (lk_sp.array)
    );

    immu_miss_ctrl u_miss_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_flag      (flush_flag),
        .miss            (miss),
        .advance         (advance),
        .immu_miss_ready (immu_miss_ready),
        .pte_valid       (pte_valid),
        .pte_error       (pte_error),
        .immu_miss_valid (immu_miss_valid),
        .pte_ready       (pte_ready),
        .walk_resp       (walk_resp),
        .walk_error      (walk_error),
        .fill            (fill)
    );

    immu_translate u_translate (
        .clk                 (clk),
        .rst_n               (rst_n),
        .flush_flag          (flush_flag),
        .current_priv_status (current_priv_status),
        .satp_mode           (satp_mode),
        .mmu_fifo_valid      (mmu_fifo_valid),
        .mmu_fifo_ready      (mmu_fifo_ready),
        .vaddr               (vaddr),
        .pte                 (pte),
        .walk_resp           (walk_resp),
        .walk_error          (walk_error),
        .hit_4k              (lk_4k.reader),
        .hit_sp              (lk_sp.reader),
        .miss                (miss),
        .advance             (advance),
        .paddr_valid         (paddr_valid),
        .paddr_ready         (paddr_ready),
        .paddr               (paddr),
        .paddr_error         (paddr_error)
    );

endmodule

//--- hw/immu_miss_ctrl.sv
`timescale 1ns/100ps

module immu_miss_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic flush_flag,
    input  logic miss,
    input  logic advance,
    input  logic immu_miss_ready,
    input  logic pte_valid,
    input  logic pte_error,
    output logic immu_miss_valid,
    output logic pte_ready,
    output logic walk_resp,
    output logic walk_error,
    output logic fill
);

    typedef enum logic [1:0] {
        S_IDLE   = 2'd0,
        S_SUBMIT = 2'd1,
        S_WAIT   = 2'd3
    } state_t;

    state_t state;

    //************************************************************
    // walker request fsm
    //************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else if (flush_flag) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        state <= S_SUBMIT;
                    end
                end
                S_SUBMIT: begin
                    if (immu_miss_ready) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    // response only taken when the output slot is free
                    if (walk_resp && advance) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign immu_miss_valid = (state == S_SUBMIT);
    assign pte_ready       = (state == S_WAIT);

    assign walk_resp  = pte_ready && pte_valid;
    assign walk_error = walk_resp && pte_error;

    // faulting ptes never reach the arrays
    assign fill = walk_resp && advance && !pte_error;

endmodule

//--- hw/immu_pkg.sv
package immu_pkg;

    //************************************************************
    // word widths
    //************************************************************
    localparam int VADDR_W = 64;
    localparam int PTE_W   = 128;
    localparam int ASID_W  = 16;

    //************************************************************
    // pte / tlb entry layout
    //************************************************************
    localparam int PTE_LVL_LSB  = 0;
    localparam int PTE_LVL_MSB  = 2;

    // virtual page tag with vpn2 at the top
    localparam int PTE_TAG_MSB  = 57;
    localparam int PTE_TAG_LSB  = 31;

    localparam int PTE_X        = 61;
    localparam int PTE_U        = 62;
    localparam int PTE_G        = 63;

    localparam int PTE_PPN_MSB  = 111;
    localparam int PTE_PPN_LSB  = 68;

    localparam int PTE_ASID_MSB = 127;
    localparam int PTE_ASID_LSB = 112;

    // page level codes
    localparam logic [2:0] LVL_4K = 3'd0;
    localparam logic [2:0] LVL_2M = 3'd1;
    localparam logic [2:0] LVL_1G = 3'd2;

    //************************************************************
    // privilege and satp
    //************************************************************
    localparam logic [1:0] PRV_M     = 2'd3;
    localparam logic [3:0] SATP_BARE = 4'd0;

    // bits above this one must copy it in sv39
    localparam int VA_SIG_MSB = 38;

endpackage

//--- hw/immu_translate.sv
`timescale 1ns/100ps

module immu_translate import immu_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               flush_flag,
    input  logic [1:0]         current_priv_status,
    input  logic [3:0]         satp_mode,
    input  logic               mmu_fifo_valid,
    output logic               mmu_fifo_ready,
    input  logic [VADDR_W-1:0] vaddr,
    input  logic [PTE_W-1:0]   pte,
    input  logic               walk_resp,
    input  logic               walk_error,
    tlb_lookup_if.reader       hit_4k,
    tlb_lookup_if.reader       hit_sp,
    output logic               miss,
    output logic               advance,
    output logic               paddr_valid,
    input  logic               paddr_ready,
    output logic [VADDR_W-1:0] paddr,
    output logic               paddr_error
);

    logic               bypass;
    logic               canonical;
    logic               any_hit;
    logic               accept;
    logic [PTE_W-1:0]   sel;
    logic [2:0]         lvl;
    logic [PTE_PPN_MSB-PTE_PPN_LSB:0] ppn;
    logic [VADDR_W-1:0] paddr_d;
    logic               error_d;

    assign bypass = (current_priv_status == PRV_M) || (satp_mode == SATP_BARE);

    // upper bits all equal to bit 38
    assign canonical = (&vaddr[VADDR_W-1:VA_SIG_MSB]) || !(|vaddr[VADDR_W-1:VA_SIG_MSB]);

    assign any_hit = hit_4k.hit || hit_sp.hit;

    //************************************************************
    // entry select and address formation
    //************************************************************
    always_comb begin
        if (hit_4k.hit) begin
            sel = hit_4k.entry;
        end else if (hit_sp.hit) begin
            sel = hit_sp.entry;
        end else begin
            sel = pte;
        end
    end

    assign lvl = sel[PTE_LVL_MSB:PTE_LVL_LSB];
    assign ppn = sel[PTE_PPN_MSB:PTE_PPN_LSB];

    always_comb begin
        if (bypass) begin
            paddr_d = vaddr;
        end else begin
            case (lvl)
                LVL_2M:  paddr_d = {8'h0, ppn[43:9], vaddr[20:0]};
                LVL_1G:  paddr_d = {8'h0, ppn[43:18], vaddr[29:0]};
                default: paddr_d = {8'h0, ppn, vaddr[11:0]};
            endcase
        end
    end

    // no-execute, u/s mismatch, bad address or walker fault
    assign error_d = !bypass && (!canonical
                              || !sel[PTE_X]
                              || (current_priv_status[0] == sel[PTE_U])
                              || walk_error);

    //************************************************************
    // handshake
    //************************************************************
    assign advance = paddr_ready || !paddr_valid;
    assign miss    = mmu_fifo_valid && !bypass && !any_hit && canonical;
    assign accept  = mmu_fifo_valid && advance
                  && (bypass || any_hit || !canonical || walk_resp);

    assign mmu_fifo_ready = accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddr_valid <= 1'b0;
        end else if (flush_flag) begin
            paddr_valid <= 1'b0;
        end else if (advance) begin
            paddr_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            paddr       <= paddr_d;
            paddr_error <= error_d;
        end
    end

endmodule

//--- hw/plru_tree.sv
`timescale 1ns/100ps

module plru_tree #(
    parameter int WAYS = 8
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            touch,
    input  logic [WAYS-1:0] touch_sel,
    input  logic            replace,
    output logic [WAYS-1:0] victim
);

    localparam int LEVELS = $clog2(WAYS);

    // heap order with the children of node n at 2n+1 and 2n+2
    logic [WAYS-2:0]   tree;
    logic [WAYS-2:0]   tree_next;
    logic [LEVELS-1:0] victim_idx;
    logic [LEVELS-1:0] touch_idx;
    logic [LEVELS-1:0] use_idx;

    // follow the lru pointers down from the root
    always_comb begin : walk
        int node;
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            node = 2 * node + 1 + int'(tree[node]);
        end
        victim_idx = LEVELS'(node - (WAYS - 1));
    end

    assign victim = WAYS'(1) << victim_idx;

    always_comb begin
        touch_idx = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (touch_sel[w]) begin
                touch_idx = touch_idx | LEVELS'(w);
            end
        end
    end

    // a fill uses the victim way
    assign use_idx = replace ? victim_idx : touch_idx;

    // point every node on the path away from the used way
    always_comb begin : update
        int node;
        tree_next = tree;
        node = 0;
        for (int l = LEVELS - 1; l >= 0; l--) begin
            tree_next[node] = ~use_idx[l];
            node = 2 * node + 1 + int'(use_idx[l]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree <= '0;
        end else if (touch || replace) begin
            tree <= tree_next;
        end
    end

endmodule

//--- hw/tlb_4k_array.sv
`timescale 1ns/100ps

module tlb_4k_array import immu_pkg::*; #(
    parameter int NUM_4K = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sflush,
    tlb_lookup_if.array   lk
);

    logic [PTE_W-1:0]  mem [NUM_4K];
    logic [NUM_4K-1:0] valid;
    logic [NUM_4K-1:0] hit_vec;
    logic [NUM_4K-1:0] victim;
    logic [PTE_W-1:0]  entry_sel;
    logic              wen;

    assign wen = lk.fill && (lk.fill_pte[PTE_LVL_MSB:PTE_LVL_LSB] == LVL_4K);

    //************************************************************
    // tag and asid compare
    //************************************************************
    for (genvar i = 0; i < NUM_4K; i++) begin : g_match
        logic tag_ok;
        logic asid_ok;
        assign tag_ok  = mem[i][PTE_TAG_MSB:PTE_TAG_LSB] == lk.vaddr[VA_SIG_MSB:12];
        assign asid_ok = (mem[i][PTE_ASID_MSB:PTE_ASID_LSB] == lk.asid) || mem[i][PTE_G];
        assign hit_vec[i] = valid[i] && tag_ok && asid_ok;
    end

    // at most one way matches
    always_comb begin
        entry_sel = '0;
        for (int i = 0; i < NUM_4K; i++) begin
            if (hit_vec[i]) begin
                entry_sel = entry_sel | mem[i];
            end
        end
    end

    assign lk.hit   = |hit_vec;
    assign lk.entry = entry_sel;

    //************************************************************
    // storage
    //************************************************************
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_4K; i++) begin
            if (wen && victim[i]) begin
                mem[i] <= lk.fill_pte;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (sflush) begin
            valid <= '0;
        end else if (wen) begin
            valid <= valid | victim;
        end
    end

    plru_tree #(
        .WAYS (NUM_4K)
    ) u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .touch     (lk.lookup_take && lk.hit),
        .touch_sel (hit_vec),
        .replace   (wen),
        .victim    (victim)
    );

endmodule

//--- hw/tlb_lookup_if.sv
`timescale 1ns/100ps

interface tlb_lookup_if import immu_pkg::*; ();

    // lookup side
    logic [VADDR_W-1:0] vaddr;
    logic [ASID_W-1:0]  asid;
    logic               lookup_take;

    // refill from walker
    logic               fill;
    logic [PTE_W-1:0]   fill_pte;

    // result
    logic               hit;
    logic [PTE_W-1:0]   entry;

    modport array (
        input  vaddr,
        input  asid,
        input  lookup_take,
        input  fill,
        input  fill_pte,
        output hit,
        output entry
    );

    modport reader (
        input  hit,
        input  entry
    );

endinterface

//--- hw/tlb_sp_array.sv
`timescale 1ns/100ps

module tlb_sp_array import immu_pkg::*; #(
    parameter int NUM_SP = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sflush,
    tlb_lookup_if.array   lk
);

    // tag slices for superpage compare
    localparam int TAG_1G_LSB = PTE_TAG_MSB - 8;
    localparam int TAG_2M_LSB = PTE_TAG_MSB - 17;

    logic [PTE_W-1:0]  mem [NUM_SP];
    logic [NUM_SP-1:0] valid;
    logic [NUM_SP-1:0] hit_vec;
    logic [NUM_SP-1:0] victim;
    logic [PTE_W-1:0]  entry_sel;
    logic              wen;

    // 2M and 1G pages share this array
    assign wen = lk.fill && (lk.fill_pte[PTE_LVL_MSB:PTE_LVL_LSB] != LVL_4K);

    //************************************************************
    // level-dependent match
    //************************************************************
    for (genvar i = 0; i < NUM_SP; i++) begin : g_match
        logic [2:0] lvl;
        logic       asid_ok;
        logic       hit_1g;
        logic       hit_2m;
        assign lvl     = mem[i][PTE_LVL_MSB:PTE_LVL_LSB];
        assign asid_ok = (mem[i][PTE_ASID_MSB:PTE_ASID_LSB] == lk.asid) || mem[i][PTE_G];
        assign hit_1g  = (lvl == LVL_1G)
                      && (mem[i][PTE_TAG_MSB:TAG_1G_LSB] == lk.vaddr[VA_SIG_MSB:30]);
        assign hit_2m  = (lvl == LVL_2M)
                      && (mem[i][PTE_TAG_MSB:TAG_2M_LSB] == lk.vaddr[VA_SIG_MSB:21]);
        assign hit_vec[i] = valid[i] && asid_ok && (hit_1g || hit_2m);
    end

    always_comb begin
        entry_sel = '0;
        for (int i = 0; i < NUM_SP; i++) begin
            if (hit_vec[i]) begin
                entry_sel = entry_sel | mem[i];
            end
        end
    end

    assign lk.hit   = |hit_vec;
    assign lk.entry = entry_sel;

    //************************************************************
    // storage
    //************************************************************
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SP; i++) begin
            if (wen && victim[i]) begin
                mem[i] <= lk.fill_pte;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (sflush) begin
            valid <= '0;
        end else if (wen) begin
            valid <= valid | victim;
        end
    end

    plru_tree #(
        .WAYS (NUM_SP)
    ) u_plru (
        .clk       (clk),
        .rst_n     (rst_n),
        .touch     (lk.lookup_take && lk.hit),
        .touch_sel (hit_vec),
        .replace   (wen),
        .victim    (victim)
    );

endmodule

//--- immu.f
hw/immu_pkg.sv
hw/tlb_lookup_if.sv
hw/plru_tree.sv
hw/tlb_4k_array.sv
hw/tlb_sp_array.sv
hw/immu_miss_ctrl.sv
hw/immu_translate.sv
hw/immu.sv
testbench/immu_assert.sv
testbench/immu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the immu testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module immu_tb -f immu.f -o immu_sim \
    && ./obj_dir/immu_sim | tee /dev/stderr | grep -qx '=== PASS ===' \
    && exit 0 \
    || exit 1

//--- testbench/immu_assert.sv
`timescale 1ns/100ps

module immu_assert import immu_pkg::*; (
    input logic               clk,
    input logic               rst_n,
    input logic               flush_flag,
    input logic               immu_miss_valid,
    input logic               immu_miss_ready,
    input logic               pte_ready,
    input logic               paddr_valid,
    input logic               paddr_ready,
    input logic               paddr_error,
    input logic [VADDR_W-1:0] paddr
);

    // walker request holds until taken
    a_miss_hold: assert property (@(posedge clk) disable iff (!rst_n)
        immu_miss_valid && !immu_miss_ready && !flush_flag |=> immu_miss_valid)
        else $error("walker request dropped before ready");

    // output word frozen under back-pressure
    a_paddr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        paddr_valid && !paddr_ready && !flush_flag
        |=> paddr_valid && $stable(paddr) && $stable(paddr_error))
        else $error("paddr changed while stalled");

    // response phase alone follows a taken request
    a_req_to_resp: assert property (@(posedge clk) disable iff (!rst_n)
        immu_miss_valid && immu_miss_ready && !flush_flag
        |=> pte_ready && !immu_miss_valid)
        else $error("no response phase after the walker request was taken");

    // control outputs quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst_n) |-> !paddr_valid && !immu_miss_valid && !pte_ready)
        else $error("control outputs active after reset");

endmodule

bind immu immu_assert u_immu_assert (.*);

//--- testbench/immu_tb.sv
`timescale 1ns/100ps

module immu_tb import immu_pkg::*; ();

    localparam int N4K = 32;
    localparam int NSP = 8;
    localparam int NPG = 60;
    localparam int MAX_ACCESSES = 420;
    localparam int MAX_CYC = 80;

    logic clk, rst_n, flush_flag, sflush_vma_valid;
    logic [1:0] current_priv_status;
    logic [3:0] satp_mode;
    logic [ASID_W-1:0] satp_asid;
    logic immu_miss_valid, immu_miss_ready, pte_valid, pte_ready, pte_error;
    logic [PTE_W-1:0] pte;
    logic mmu_fifo_valid, mmu_fifo_ready;
    logic [VADDR_W-1:0] vaddr, paddr;
    logic paddr_valid, paddr_ready, paddr_error;

    int seed;
    int errs, checks, t_err, ntests, acc_total, xfers;
    string test_name;

    // page table seen by the walker
    logic [2:0]  pg_lvl [NPG];
    logic [43:0] pg_ppn [NPG];
    bit pg_g [NPG];
    bit pg_x [NPG];
    bit pg_u [NPG];
    bit pg_err [NPG];

    // mirror of both arrays with index 0 for 4k and 1 for superpages
    bit [30:0]   tree [2];
    bit          mv [2][32];
    int          m_page [2][32];
    logic [15:0] m_asid [2][32];

    // expected outputs in fetch order
    logic [63:0] exp_pa_q [$];
    logic        exp_err_q [$];
    bit          pa_known_q [$];

    immu #(.NUM_4K(N4K), .NUM_SP(NSP)) immu_i (.*);

    always #50 clk = ~clk;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % $unsigned(n));
    endfunction

    function automatic int ways_of(input int a);
        return (a == 1) ? NSP : N4K;
    endfunction

    function automatic int pick_victim(input int a);
        int node;
        node = 0;
        for (int l = 0; l < $clog2(ways_of(a)); l++) begin
            node = 2 * node + 1 + int'(tree[a][node]);
        end
        return node - (ways_of(a) - 1);
    endfunction

    task automatic mark_used(input int a, input int w);
        int node;
        int b;
        node = 0;
        for (int l = $clog2(ways_of(a)) - 1; l >= 0; l--) begin
            b = (w >> l) & 1;
            tree[a][node] = (b == 0);
            node = 2 * node + 1 + b;
        end
    endtask

    function automatic int find_way(input int a, input int p, input logic [15:0] asid);
        for (int i = 0; i < ways_of(a); i++) begin
            if (mv[a][i] && m_page[a][i] == p && (m_asid[a][i] == asid || pg_g[p])) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic logic [63:0] page_va(input int p);
        logic [63:0] va;
        va = 64'(p) << 30;
        case (pg_lvl[p])
            LVL_4K:  va[11:0] = 12'(rnd(4096));
            LVL_2M:  va[20:0] = 21'(rnd(1 << 21));
            default: va[29:0] = 30'(rnd(1 << 30));
        endcase
        return va;
    endfunction

    function automatic logic [127:0] make_pte(input logic [63:0] va, input logic [15:0] asid);
        int p;
        logic [127:0] e;
        p = int'(va[35:30]);
        e = '0;
        e[PTE_LVL_MSB:PTE_LVL_LSB] = pg_lvl[p];
        e[PTE_TAG_MSB:PTE_TAG_LSB] = va[38:12];
        e[PTE_X] = pg_x[p];
        e[PTE_U] = pg_u[p];
        e[PTE_G] = pg_g[p];
        e[PTE_PPN_MSB:PTE_PPN_LSB] = pg_ppn[p];
        e[PTE_ASID_MSB:PTE_ASID_LSB] = asid;
        return e;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] got);
        checks++;
        assert (exp === got) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, got);
            errs++;
            t_err++;
        end
    endtask

    //************************************************************
    // walker model and output sink
    //************************************************************
    always begin : walker
        int d;
        bit taken;
        @(negedge clk);
        if (rst_n && immu_miss_valid) begin
            d = 1 + rnd(3);
            repeat (d) @(posedge clk);
            #1 immu_miss_ready = 1'b1;
            @(negedge clk);
            taken = immu_miss_valid;
            @(posedge clk);
            #1 immu_miss_ready = 1'b0;
            if (taken) begin
                repeat (rnd(4)) @(posedge clk);
                #1;
                pte = make_pte(vaddr, satp_asid);
                pte_error = pg_err[int'(vaddr[35:30])];
                pte_valid = 1'b1;
                @(posedge clk);
                #1;
                while (pte_ready) begin
                    @(posedge clk);
                    #1;
                end
                pte_valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        #1 paddr_ready = (rnd(2) == 1);
    end

    always @(negedge clk) begin : out_check
        logic [63:0] e_pa;
        logic        e_err;
        bit          known;
        if (paddr_valid && paddr_ready) begin
            xfers++;
            checks++;
            assert (exp_pa_q.size() != 0) else begin
                $display("%s: output transfer with no fetch pending", test_name);
                errs++;
                t_err++;
            end
            if (exp_pa_q.size() != 0) begin
                e_pa = exp_pa_q.pop_front();
                e_err = exp_err_q.pop_front();
                known = pa_known_q.pop_front();
                if (known) begin
                    check_val("paddr", e_pa, paddr);
                end
                check_val("error", 64'(e_err), 64'(paddr_error));
            end
        end
    end

    //************************************************************
    // one fetch through the DUT checked against the mirror
    //************************************************************
    task automatic do_access(input logic [63:0] va, input logic [1:0] priv,
                             input logic [3:0] mode, input logic [15:0] asid);
        int p;
        int a;
        int w;
        int v;
        int off_w;
        logic byp, canon, exp_miss, saw_miss, exp_err;
        logic [63:0] exp_pa;
        logic [63:0] mask;
        p = int'(va[35:30]);
        a = (pg_lvl[p] == LVL_4K) ? 0 : 1;
        byp = (priv == PRV_M) || (mode == SATP_BARE);
        canon = (va[63:38] == '0) || (&va[63:38]);
        w = find_way(a, p, asid);
        exp_miss = !byp && canon && (w < 0);
        saw_miss = 1'b0;
        @(posedge clk);
        #1;
        current_priv_status = priv;
        satp_mode = mode;
        satp_asid = asid;
        vaddr = va;
        mmu_fifo_valid = 1'b1;
        @(negedge clk);
        while (!mmu_fifo_ready) begin
            if (immu_miss_valid) begin
                saw_miss = 1'b1;
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1 mmu_fifo_valid = 1'b0;
        // touch the mirror on a hit or fill its victim
        if (w >= 0) begin
            mark_used(a, w);
        end else if (exp_miss && !pg_err[p]) begin
            v = pick_victim(a);
            mv[a][v] = 1'b1;
            m_page[a][v] = p;
            m_asid[a][v] = asid;
            mark_used(a, v);
        end
        // page offset taken from va grows with the level
        case (pg_lvl[p])
            LVL_2M:  off_w = 21;
            LVL_1G:  off_w = 30;
            default: off_w = 12;
        endcase
        mask = (64'h1 << off_w) - 64'h1;
        if (byp) begin
            exp_pa = va;
            exp_err = 1'b0;
        end else begin
            exp_pa = ({8'h0, pg_ppn[p], 12'h0} & ~mask) | (va & mask);
            exp_err = !canon || !pg_x[p] || (priv[0] == pg_u[p]) || (exp_miss && pg_err[p]);
        end
        check_val("miss", 64'(exp_miss), 64'(saw_miss));
        exp_pa_q.push_back(exp_pa);
        exp_err_q.push_back(exp_err);
        pa_known_q.push_back(byp || canon);
        acc_total++;
    endtask

    task automatic run_test(input string name, input int n, input int pool, input int nc_pct,
                            input bit mix_asid, input bit bypass_mode);
        logic [63:0] va;
        logic [1:0] priv;
        logic [3:0] mode;
        test_name = name;
        t_err = 0;
        for (int i = 0; i < n; i++) begin
            priv = 2'(rnd(2));
            mode = 4'd8;
            if (bypass_mode) begin
                if (rnd(2) == 1) begin
                    priv = PRV_M;
                end else begin
                    mode = SATP_BARE;
                end
            end
            va = page_va(rnd(pool));
            if (rnd(100) < nc_pct) begin
                va = va | (64'h1 << (39 + rnd(25)));
            end
            do_access(va, priv, mode, mix_asid ? 16'(1 + rnd(2)) : 16'd1);
        end
        while (exp_pa_q.size() != 0) begin
            @(negedge clk);
        end
        ntests++;
        $display("test %-12s accesses %0d errors %0d", name, n, t_err);
    endtask

    task automatic pulse_sflush();
        @(posedge clk);
        #1 sflush_vma_valid = 1'b1;
        @(posedge clk);
        #1 sflush_vma_valid = 1'b0;
        for (int a = 0; a < 2; a++) begin
            for (int i = 0; i < 32; i++) begin
                mv[a][i] = 1'b0;
            end
        end
    endtask

    // pipeline flush while a miss is pending
    task automatic flush_test(input int n);
        int cyc;
        test_name = "flush";
        t_err = 0;
        pulse_sflush();
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            current_priv_status = 2'd1;
            satp_mode = 4'd8;
            vaddr = page_va(rnd(NPG));
            mmu_fifo_valid = 1'b1;
            cyc = 0;
            @(negedge clk);
            while (!immu_miss_valid && cyc < 20) begin
                cyc++;
                @(negedge clk);
            end
            checks++;
            assert (immu_miss_valid) else begin
                $display("flush: no walker request for a page that is not in any TLB");
                errs++;
                t_err++;
            end
            @(posedge clk);
            #1;
            flush_flag = 1'b1;
            mmu_fifo_valid = 1'b0;
            @(posedge clk);
            #1 flush_flag = 1'b0;
            repeat (10) begin
                @(negedge clk);
                checks++;
                assert (!paddr_valid && !immu_miss_valid) else begin
                    $display("flush: output or walker request seen after pipeline flush");
                    errs++;
                    t_err++;
                end
            end
        end
        ntests++;
        $display("test %-12s accesses %0d errors %0d", "flush", n, t_err);
    endtask

    initial begin
        #(MAX_ACCESSES * MAX_CYC * 100);
        $display("timeout: the tests did not finish in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        flush_flag = 1'b0;
        sflush_vma_valid = 1'b0;
        current_priv_status = 2'd1;
        satp_mode = 4'd8;
        satp_asid = 16'd1;
        immu_miss_ready = 1'b0;
        pte_valid = 1'b0;
        pte = '0;
        pte_error = 1'b0;
        mmu_fifo_valid = 1'b0;
        vaddr = '0;
        paddr_ready = 1'b0;
        errs = 0;
        checks = 0;
        ntests = 0;
        acc_total = 0;
        xfers = 0;
        seed = 32'h4878fdf7;
        for (int p = 0; p < NPG; p++) begin
            // mostly 4k pages so both arrays overflow
            pg_lvl[p] = (rnd(4) != 0) ? LVL_4K : ((rnd(2) == 1) ? LVL_2M : LVL_1G);
            pg_ppn[p] = {12'(rnd(4096)), 32'($random(seed))};
            pg_g[p] = (rnd(4) == 0);
            pg_x[p] = (rnd(8) != 0);
            pg_u[p] = (rnd(2) == 1);
            pg_err[p] = (rnd(10) == 0);
        end
        for (int a = 0; a < 2; a++) begin
            tree[a] = '0;
            for (int i = 0; i < 32; i++) begin
                mv[a][i] = 1'b0;
            end
        end
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        run_test("bypass", 20, NPG, 0, 1'b0, 1'b1);
        run_test("fill", 40, 8, 0, 1'b0, 1'b0);
        run_test("replace", 120, NPG, 0, 1'b0, 1'b0);
        run_test("errors", 40, 16, 30, 1'b0, 1'b0);
        run_test("asid", 40, 16, 0, 1'b1, 1'b0);
        pulse_sflush();
        run_test("sflush", 30, 8, 0, 1'b0, 1'b0);
        flush_test(5);
        run_test("backpressure", 80, NPG, 5, 1'b1, 1'b0);

        // late or repeated outputs show up in the count
        repeat (4) @(posedge clk);
        test_name = "transfers";
        check_val("count", 64'(acc_total), 64'(xfers));
        $display("tests %0d checks %0d errors %0d", ntests, checks, errs);
        if (errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
